/* board_pkg.sv */
package board_pkg;

    localparam int SAMPLE_W       = 24;
    localparam int SCK_DIV        = 4;     // clk cycles per half period of sck.
    localparam int SAMPLE_CREDITS = 2;
    localparam int TICK_CYCLES    = 65536;
    localparam int SIO_DIV        = 4;     // clk cycles per half period of sio_clk.
    localparam int N_DIGITS       = 8;

    typedef enum logic [1:0] {IDLE_WS, SHIFT, SKIP} i2s_state_t;

    typedef enum logic [2:0] {START, CMD, ADDR, DATA, KEYCMD, KEYREAD, STOP} tm_state_t;

    typedef enum logic [7:0]
    {
        WRITE_AUTO = 8'h40,
        READ_KEYS  = 8'h42,
        ADDR0      = 8'hC0,
        DISPLAY_ON = 8'h8F
    } tm_cmd_t;

    // Segment a is the msb and the decimal point h is the lsb.
    function automatic logic [7:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

/* sample_if.sv */
`timescale 1ns/1ns

interface sample_if
    import board_pkg::*;
();

    logic                       valid;  // one cycle per word sent.
    logic signed [SAMPLE_W-1:0] value;
    logic                       credit; // each pulse returns one credit to the receiver.

    modport source
    (
        output valid,
        output value,
        input  credit
    );

    modport sink
    (
        input  valid,
        input  value,
        output credit
    );

endinterface

/* panel_if.sv */
`timescale 1ns/1ns

interface panel_if
    import board_pkg::*;
();

    logic [7:0] abcdefgh [N_DIGITS];   // digit 0 is the rightmost one.
    logic [7:0] led;
    logic [7:0] keys;
    logic       keys_valid;            // pulses once per completed key scan.

    modport display
    (
        output abcdefgh,
        output led,
        input  keys,
        input  keys_valid
    );

    modport panel
    (
        input  abcdefgh,
        input  led,
        output keys,
        output keys_valid
    );

endinterface

/* tick_gen.sv */
`timescale 1ns/1ns

module tick_gen
    import board_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    logic [$clog2(TICK_CYCLES)-1:0] cnt;
    logic                           wrap;

    assign wrap = (cnt == TICK_CYCLES - 1);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;  // registered, so the first tick lands TICK_CYCLES edges after reset.
        end
    end

    a_tick_single: assert property (@(posedge clk) disable iff (!arst_n)
        tick |=> !tick);

endmodule

/* inmp441_i2s_receiver.sv */
`timescale 1ns/1ns

module inmp441_i2s_receiver
    import board_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    output logic     sck,
    output logic     ws,
    output logic     lr,
    input  logic     sd,
    sample_if.source smp
);

    logic [$clog2(SCK_DIV)-1:0]          div_cnt;
    logic [5:0]                          slot;      // sck period within the 64-period frame.
    logic [5:0]                          slot_next;
    logic [4:0]                          bit_cnt;
    logic [SAMPLE_W-1:0]                 shreg;
    logic [$clog2(SAMPLE_CREDITS+1)-1:0] credits;
    i2s_state_t                          state;
    logic                                sck_edge;
    logic                                rise;
    logic                                fall;
    logic                                word_end;

    assign lr        = 1'b0;                      // the microphone talks in the left slot.
    assign sck_edge  = (div_cnt == SCK_DIV - 1);
    assign rise      = sck_edge && !sck;
    assign fall      = sck_edge && sck;
    assign slot_next = slot + 6'd1;
    assign word_end  = rise && (state == SHIFT) && (bit_cnt == SAMPLE_W - 1);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            ws      <= 1'b0;
            slot    <= '0;
        end
        else
        begin
            div_cnt <= sck_edge ? '0 : div_cnt + 1'b1;
            if (sck_edge)
                sck <= !sck;
            if (fall)
            begin
                slot <= slot_next;
                ws   <= slot_next[5];  // low for slots 0 to 31, high for the right half.
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= IDLE_WS;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE_WS:
                    if (rise && slot == '0)
                    begin
                        state   <= SHIFT;    // slot 0 carries no data, the msb follows.
                        bit_cnt <= '0;
                    end
                SHIFT:
                    if (rise)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == SAMPLE_W - 1)
                            state <= SKIP;
                    end
                SKIP:
                    if (ws)
                        state <= IDLE_WS;    // wait out the right half of the frame.
                default:
                    state <= IDLE_WS;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rise && state == SHIFT)
            shreg <= {shreg[SAMPLE_W-2:0], sd};
        if (word_end)
            smp.value <= {shreg[SAMPLE_W-2:0], sd};
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            smp.valid <= 1'b0;
            credits   <= ($bits(credits))'(SAMPLE_CREDITS);
        end
        else
        begin
            smp.valid <= word_end && (credits != '0);  // with no credit left the word is lost.
            credits   <= credits - smp.valid + smp.credit;
        end
    end

    a_valid_has_credit: assert property (@(posedge clk) disable iff (!arst_n)
        smp.valid |-> credits != '0);

    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= SAMPLE_CREDITS);

endmodule

/* tm1638_board_controller.sv */
`timescale 1ns/1ns

module tm1638_board_controller
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    output logic   sio_clk,
    output logic   sio_stb,
    inout  wire    sio_data,
    panel_if.panel pnl
);

    tm_state_t                  state;
    logic [1:0]                 txn;       // which of the four transactions of the loop.
    logic [3:0]                 half;      // half periods of sio_clk within a byte.
    logic [3:0]                 byte_cnt;
    logic [3:0]                 next_idx;
    logic [$clog2(SIO_DIV)-1:0] div_cnt;
    logic [7:0]                 shreg;
    logic [7:0]                 rx_byte;
    logic [7:0]                 seg_rev;
    logic [7:0]                 next_byte;
    logic [7:0]                 keys_acc;
    logic                       step;
    logic                       data_o;
    logic                       data_oe;

    assign sio_data = data_oe ? data_o : 1'bz;
    assign step     = (div_cnt == SIO_DIV - 1);
    assign rx_byte  = {sio_data, shreg[7:1]};            // bits arrive lsb first.
    assign next_idx = (state == ADDR) ? 4'd0 : byte_cnt + 4'd1;
    assign seg_rev  = {<<{pnl.abcdefgh[next_idx[3:1]]}}; // the chip wants segment a in bit 0.
    assign next_byte = next_idx[0] ? {7'd0, pnl.led[next_idx[3:1]]} : seg_rev;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state          <= START;
            txn            <= '0;
            half           <= '0;
            byte_cnt       <= '0;
            div_cnt        <= '0;
            shreg          <= '0;
            sio_clk        <= 1'b1;
            sio_stb        <= 1'b1;
            data_o         <= 1'b0;
            data_oe        <= 1'b0;
            keys_acc       <= '0;
            pnl.keys       <= '0;
            pnl.keys_valid <= 1'b0;
        end
        else
        begin
            div_cnt        <= step ? '0 : div_cnt + 1'b1;
            pnl.keys_valid <= 1'b0;
            if (step)
            begin
                case (state)
                    START:
                    begin
                        sio_stb <= 1'b0;
                        half    <= '0;
                        case (txn)
                            2'd0:
                            begin
                                state <= CMD;
                                shreg <= WRITE_AUTO;
                            end
                            2'd1:
                            begin
                                state <= ADDR;
                                shreg <= ADDR0;
                            end
                            2'd2:
                            begin
                                state <= CMD;
                                shreg <= DISPLAY_ON;
                            end
                            default:
                            begin
                                state <= KEYCMD;
                                shreg <= READ_KEYS;
                            end
                        endcase
                    end
                    STOP:
                    begin
                        data_oe <= 1'b0;
                        if (!sio_stb)
                        begin
                            sio_stb <= 1'b1;
                            if (txn == 2'd3)
                            begin
                                pnl.keys       <= keys_acc;  // a scan is complete.
                                pnl.keys_valid <= 1'b1;
                            end
                        end
                        else
                        begin
                            state <= START;
                            txn   <= txn + 1'b1;
                        end
                    end
                    default:
                    begin
                        half <= half + 1'b1;
                        if (!half[0])
                        begin
                            sio_clk <= 1'b0;
                            if (state != KEYREAD)
                            begin
                                data_oe <= 1'b1;
                                data_o  <= shreg[0];  // data moves only while sio_clk is low.
                            end
                        end
                        else
                        begin
                            sio_clk <= 1'b1;
                            shreg   <= rx_byte;      // one shifter serves both directions.
                            if (half == 4'd15)
                            begin
                                case (state)
                                    ADDR:
                                    begin
                                        state    <= DATA;
                                        byte_cnt <= '0;
                                        shreg    <= next_byte;
                                    end
                                    DATA:
                                        if (byte_cnt == 4'd15)
                                            state <= STOP;
                                        else
                                        begin
                                            byte_cnt <= next_idx;
                                            shreg    <= next_byte;
                                        end
                                    KEYCMD:
                                    begin
                                        state    <= KEYREAD;
                                        byte_cnt <= '0;
                                        data_oe  <= 1'b0;  // the chip drives the read bytes.
                                    end
                                    KEYREAD:
                                    begin
                                        keys_acc[{1'b0, byte_cnt[1:0]}] <= rx_byte[0];
                                        keys_acc[{1'b1, byte_cnt[1:0]}] <= rx_byte[4];
                                        if (byte_cnt == 4'd3)
                                            state <= STOP;
                                        else
                                            byte_cnt <= byte_cnt + 1'b1;
                                    end
                                    default:
                                        state <= STOP;
                                endcase
                            end
                        end
                    end
                endcase
            end
        end
    end

    a_stb_frames_clk: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(sio_clk) |-> !sio_stb && !$past(sio_stb));

endmodule

/* lab_top.sv */
`timescale 1ns/1ns

module lab_top
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       tick,
    input  logic [3:0] sw,
    output logic [3:0] led,
    sample_if.sink     smp,
    panel_if.display   pnl
);

    logic [SAMPLE_W-1:0]                 peak;
    logic [SAMPLE_W-1:0]                 base;
    logic [SAMPLE_W-1:0]                 mag;
    logic [$clog2(SAMPLE_CREDITS+1)-1:0] owed;      // credits held back during freeze.
    logic [7:0]                          key_seen;
    logic                                freeze;
    logic                                clear;

    assign freeze = sw[0];
    assign clear  = pnl.keys_valid && pnl.keys[0];
    assign mag    = smp.value[SAMPLE_W-1] ? $unsigned(-smp.value) : $unsigned(smp.value);
    assign base   = tick ? peak >> 1 : peak;       // the decayed peak is what a sample competes with.

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            peak <= '0;
        else if (clear)
            peak <= '0;
        else if (smp.valid && mag > base)
            peak <= mag;
        else
            peak <= base;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            smp.credit <= 1'b0;
            owed       <= '0;
            key_seen   <= '0;
        end
        else
        begin
            smp.credit <= !freeze && (smp.valid || owed != '0);
            if (smp.valid && freeze)
                owed <= owed + 1'b1;
            else if (!freeze && !smp.valid && owed != '0)
                owed <= owed - 1'b1;  // pay back one owed credit per cycle.
            if (pnl.keys_valid)
                key_seen <= pnl.keys;
        end
    end

    assign pnl.led = key_seen;

    for (genvar i = 0; i < 4; i++)
    begin : g_led
        assign led[i] = (peak >> (20 + i)) != '0;
    end

    for (genvar d = 0; d < N_DIGITS; d++)
    begin : g_digit
        if (d < SAMPLE_W / 4)
        begin : g_hex
            assign pnl.abcdefgh[d] = hex_to_seg(peak[4 * d +: 4]);
        end
        else
        begin : g_blank
            assign pnl.abcdefgh[d] = 8'h00;
        end
    end

endmodule

/* board_specific_top.sv */
`timescale 1ns/1ns

module board_specific_top
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [3:0] sw,
    output logic [3:0] led,
    output logic       mic_sck,
    output logic       mic_ws,
    output logic       mic_lr,
    input  logic       mic_sd,
    output logic       sio_clk,
    output logic       sio_stb,
    inout  wire        sio_data
);

    logic tick;

    sample_if smp_bus ();
    panel_if  pnl_bus ();

    tick_gen i_tick_gen
    (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .tick   ( tick   )
    );

    inmp441_i2s_receiver i_mic
    (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .sck    ( mic_sck ),
        .ws     ( mic_ws  ),
        .lr     ( mic_lr  ),
        .sd     ( mic_sd  ),
        .smp    ( smp_bus )
    );

    lab_top i_lab_top
    (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .tick   ( tick    ),
        .sw     ( sw      ),
        .led    ( led     ),
        .smp    ( smp_bus ),
        .pnl    ( pnl_bus )
    );

    tm1638_board_controller i_ledkey
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data ),
        .pnl      ( pnl_bus  )
    );

endmodule

/* tb_board_top.sv */
`timescale 1ns/1ns

module tb_board_top
    import board_pkg::*;
();

    localparam int FRAME_CYCLES = 64 * 2 * SCK_DIV;
    localparam int LIMIT        = 6 * TICK_CYCLES + 200 * FRAME_CYCLES;

    logic       clk;
    logic       arst_n;
    logic [3:0] sw;
    logic [3:0] led;
    logic       mic_sck;
    logic       mic_ws;
    logic       mic_lr;
    logic       mic_sd;
    logic       sio_clk;
    logic       sio_stb;
    wire        sio_data;

    int                  errors;
    int                  checks;
    int                  cycles;
    int                  test_errs;
    int                  rnd;
    logic [SAMPLE_W-1:0] word;
    logic [SAMPLE_W-1:0] expected;
    logic [SAMPLE_W-1:0] frozen_words [4];

    // microphone model state.
    logic [SAMPLE_W-1:0] word_q [$];
    logic [SAMPLE_W-1:0] cur_word;
    logic                cur_real;
    int                  slot_m;
    int                  words_pushed;
    int                  words_done;
    int                  frozen_valids;

    // panel model state.
    logic [7:0] key_vec;
    logic [7:0] rx_shift;
    logic [7:0] txn_cmd;
    logic [7:0] rd_byte;
    logic [7:0] cap_seg [8];
    logic [7:0] shown_seg [8];
    logic [7:0] cap_led;
    logic [7:0] shown_led;
    logic       reading;
    logic       drive_en;
    logic       drive_bit;
    int         rx_bits;
    int         rx_bytes;
    int         rd_idx;
    int         frames;

    board_specific_top dut
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .sw       ( sw       ),
        .led      ( led      ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   ),
        .mic_sd   ( mic_sd   ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data )
    );

    assign sio_data = drive_en ? drive_bit : 1'bz;  // the panel answers only during a key read.

    function automatic logic [7:0] segment_font(input logic [3:0] n);
        logic [7:0] s;
        case (n)
            4'h0: s = 8'hFC;
            4'h1: s = 8'h60;
            4'h2: s = 8'hDA;
            4'h3: s = 8'hF2;
            4'h4: s = 8'h66;
            4'h5: s = 8'hB6;
            4'h6: s = 8'hBE;
            4'h7: s = 8'hE0;
            4'h8: s = 8'hFE;
            4'h9: s = 8'hF6;
            4'hA: s = 8'hEE;
            4'hB: s = 8'h3E;
            4'hC: s = 8'h9C;
            4'hD: s = 8'h7A;
            4'hE: s = 8'h9E;
            default: s = 8'h8E;
        endcase
        return s;
    endfunction

    function automatic logic [7:0] reverse_bits(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = b[7 - i];
        return r;
    endfunction

    function automatic logic [SAMPLE_W-1:0] magnitude(input logic [SAMPLE_W-1:0] v);
        return v[SAMPLE_W-1] ? (~v + 1'b1) : v;
    endfunction

    function automatic logic [3:0] led_bits(input logic [SAMPLE_W-1:0] p);
        logic [3:0] b;
        for (int i = 0; i < 4; i++)
            b[i] = (p >= (32'd1 << (20 + i)));
        return b;
    endfunction

    function automatic logic [7:0] key_byte(input int k);
        logic [7:0] b;
        b    = 8'h00;
        b[0] = key_vec[k];
        b[4] = key_vec[k + 4];
        return b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERROR %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_display(input logic [SAMPLE_W-1:0] peak);
        for (int d = 0; d < 6; d++)
            check_value($sformatf("digit%0d", d), shown_seg[d], segment_font(peak[4 * d +: 4]));
        check_value("digit6", shown_seg[6], 8'h00);
        check_value("digit7", shown_seg[7], 8'h00);
        check_value("led", led, led_bits(peak));
    endtask

    task automatic check_reset_pins();
        check_value("sio_stb", sio_stb, 1'b1);
        check_value("sio_clk", sio_clk, 1'b1);
        check_value("led", led, 4'h0);
        check_value("mic_sck", mic_sck, 1'b0);
        check_value("mic_ws", mic_ws, 1'b0);
        check_value("mic_lr", mic_lr, 1'b0);
    endtask

    task automatic send_word(input logic [SAMPLE_W-1:0] w);
        word_q.push_back(w);
        words_pushed++;
    endtask

    task automatic wait_sent();
        wait (words_done == words_pushed);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames + n;
        wait (frames >= target);
        @(negedge clk);
    endtask

    task automatic report_test(input string name);
        if (errors == test_errs)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (arst_n)
            cycles++;
        if (cycles > LIMIT)
        begin
            $display("timeout: the run went past %0d cycles", LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // the I2S microphone model puts the msb in slot 1 of the left half.
    always @(negedge mic_sck)
    begin
        if (arst_n)
        begin
            #1;
            slot_m = (slot_m + 1) % 64;
            check_value("mic_ws", mic_ws, slot_m >= 32);
            if (slot_m == 1)
            begin
                cur_real = (word_q.size() != 0);
                if (cur_real)
                    cur_word = word_q.pop_front();
                else
                    cur_word = '0;
            end
            if (slot_m >= 1 && slot_m <= SAMPLE_W)
                mic_sd = cur_word[SAMPLE_W - slot_m];
            else
                mic_sd = 1'b0;
            if (slot_m == SAMPLE_W + 1 && cur_real)
                words_done++;
        end
    end

    always @(negedge sio_stb)
    begin
        if (arst_n)
        begin
            rx_bits  = 0;
            rx_bytes = 0;
            rd_idx   = 0;
            txn_cmd  = 8'h00;
        end
    end

    always @(posedge sio_clk)
    begin
        if (arst_n && !sio_stb)
        begin
            rx_shift = {sio_data, rx_shift[7:1]};  // lsb first.
            rx_bits++;
            if (rx_bits == 8)
            begin
                rx_bits = 0;
                if (rx_bytes == 0)
                begin
                    txn_cmd = rx_shift;
                    reading = (rx_shift == READ_KEYS);
                end
                else if (txn_cmd == ADDR0 && rx_bytes <= 16)
                begin
                    if (rx_bytes % 2 == 1)
                        cap_seg[(rx_bytes - 1) / 2] = reverse_bits(rx_shift);
                    else
                        cap_led[(rx_bytes - 1) / 2] = rx_shift[0];
                end
                rx_bytes++;
            end
        end
    end

    always @(negedge sio_clk)
    begin
        if (arst_n && reading && !sio_stb)
        begin
            #1;
            rd_byte   = key_byte(rd_idx / 8);
            drive_bit = rd_byte[rd_idx % 8];
            drive_en  = 1'b1;
            rd_idx++;
        end
    end

    always @(posedge sio_stb)
    begin
        if (arst_n)
        begin
            if (txn_cmd == ADDR0 && rx_bytes == 17)
            begin
                for (int d = 0; d < 8; d++)
                    shown_seg[d] = cap_seg[d];
                shown_led = cap_led;
                frames++;  // a whole display frame has landed.
            end
            reading  = 1'b0;
            drive_en = 1'b0;
        end
    end

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            frozen_valids <= 0;
        else if (!sw[0])
            frozen_valids <= 0;
        else if (dut.smp_bus.valid)
            frozen_valids <= frozen_valids + 1;
    end

    a_frozen_no_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (sw[0] && frozen_valids >= SAMPLE_CREDITS) |-> !dut.smp_bus.valid)
    else
    begin
        errors++;
        $display("a sample was sent while frozen with every credit already spent");
    end

    initial
    begin
        rnd       = $urandom(32'hba434c65);
        arst_n    = 1'b0;
        sw        = 4'h0;
        mic_sd    = 1'b0;
        key_vec   = 8'h00;
        drive_en  = 1'b0;
        drive_bit = 1'b0;
        reading   = 1'b0;
        slot_m    = 0;
        frames    = 0;

        repeat (9) @(posedge clk);
        @(negedge clk);
        check_reset_pins();
        @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_reset_pins();
        report_test("reset state");

        expected = '0;
        for (int i = 0; i < 8; i++)
        begin
            rnd  = $urandom();
            word = rnd[SAMPLE_W-1:0];
            send_word(word);
            if (magnitude(word) > expected)
                expected = magnitude(word);
        end
        wait_sent();
        wait_frames(2);
        checks++;
        assert (cycles < TICK_CYCLES)
        else
        begin
            errors++;
            $display("the first decay tick came before the peak could be checked");
        end
        check_display(expected);
        report_test("peak capture");

        wait (cycles >= TICK_CYCLES + 16);
        wait_frames(2);
        expected = expected >> 1;
        check_display(expected);
        report_test("decay");

        frozen_words[0] = 24'h500000;
        frozen_words[1] = 24'hA00000;                   // a negative sample of magnitude 6 << 20.
        frozen_words[2] = 24'h7F0000;
        frozen_words[3] = 24'h7FFFFF;
        wait (slot_m == 40);                            // between frames, all credits are home.
        @(posedge clk);
        #1 sw[0] = 1'b1;
        for (int i = 0; i < 4; i++)
            send_word(frozen_words[i]);
        for (int i = 0; i < SAMPLE_CREDITS; i++)
            if (magnitude(frozen_words[i]) > expected)
                expected = magnitude(frozen_words[i]);
        wait_sent();
        wait_frames(2);
        check_display(expected);
        @(posedge clk);
        #1 sw[0] = 1'b0;
        send_word(24'h7ABCDE);
        expected = 24'h7ABCDE;
        wait_sent();
        wait_frames(2);
        check_display(expected);
        report_test("freeze and credits");

        @(posedge clk);
        #1 key_vec = 8'h01;
        wait_frames(3);
        check_display('0);
        check_value("panel_led", shown_led, 8'h01);
        report_test("key scan and clear");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* compile.f */
board_pkg.sv
sample_if.sv
panel_if.sv
tick_gen.sv
inmp441_i2s_receiver.sv
tm1638_board_controller.sv
lab_top.sv
board_specific_top.sv
tb_board_top.sv
